/* filelist.f */
src/vfu_cfg_pkg.sv
src/vfu_isa_pkg.sv
src/vfu_req_queue.sv
src/vfu_controller.sv
src/vfu_elem_counter.sv
src/vfu_operand_sel.sv
src/vfu_lane.sv
src/vfu_result_stage.sv
src/vfu_top.sv
sim/vfu_assertions.sv
sim/vfu_checker.sv
sim/vfu_tb.sv

/* sim/vfu_tb.sv */
// Testbench for the vector functional unit
// Clock, reset, VRF model with random stalls, directed and random
// request stimulus, and the closing report

`timescale 1ns/1ps

module vfu_tb import vfu_cfg_pkg::*; import vfu_isa_pkg::*;;

  localparam int TIMEOUT = 2000;

  logic            clk_i;
  logic            rst_i;
  vfu_req_t        req_i;
  logic            req_valid_i;
  logic            req_ready_o;
  vfu_rsp_t        rsp_o;
  logic            rsp_valid_o;
  logic            rsp_ready_i;
  logic      [1:0] vrf_re_o;
  vrf_addr_t [1:0] vrf_raddr_o;
  vrf_word_t [1:0] vrf_rdata_i;
  logic      [1:0] vrf_rvalid_i;
  logic            vrf_we_o;
  vrf_addr_t       vrf_waddr_o;
  vrf_word_t       vrf_wdata_o;
  vrf_be_t         vrf_wbe_o;
  logic            vrf_wvalid_i;

  vrf_word_t   mem [N_VREGS*WORDS_PER_VREG];
  int          seed;
  int          bp_seed;
  logic        bp_on;
  int          timeouts;
  logic [2:0]  next_id;
  int          errors;
  int          pending;
  int          rsp_count;

  vfu_top vfu_top_inst (.*);

  vfu_checker checker_inst (
    .clk_i (clk_i), .rst_i (rst_i),
    .req_i (req_i), .req_valid_i (req_valid_i), .req_ready_i (req_ready_o),
    .rsp_i (rsp_o), .rsp_valid_i (rsp_valid_o), .rsp_ready_i (rsp_ready_i),
    .re_i (vrf_re_o), .we_i (vrf_we_o), .waddr_i (vrf_waddr_o), .wdata_i (vrf_wdata_o),
    .wbe_i (vrf_wbe_o), .wvalid_i (vrf_wvalid_i),
    .errors_o (errors), .pending_o (pending), .rsp_count_o (rsp_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // VRF model
  ////////////////////////////////////////

  // Read data is only defined while the port is enabled
  assign vrf_rdata_i[0] = vrf_re_o[0] ? mem[vrf_raddr_o[0]] : 'x;
  assign vrf_rdata_i[1] = vrf_re_o[1] ? mem[vrf_raddr_o[1]] : 'x;

  always @(posedge clk_i) begin
    if (vrf_we_o && vrf_wvalid_i) begin
      for (int j = 0; j < VRF_BE_W; j++) begin
        if (vrf_wbe_o[j]) begin
          mem[vrf_waddr_o][j*8 +: 8] <= vrf_wdata_o[j*8 +: 8];
        end
      end
    end
  end

  // Random stalls on reads, writes and the response
  initial begin
    vrf_rvalid_i = 2'b00;
    vrf_wvalid_i = 1'b0;
    rsp_ready_i  = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      if (bp_on) begin
        vrf_rvalid_i = 2'($random(bp_seed));
        vrf_wvalid_i = ($random(bp_seed) & 3) != 0;
        rsp_ready_i  = ($random(bp_seed) & 1) != 0;
      end else begin
        vrf_rvalid_i = 2'b11;
        vrf_wvalid_i = 1'b1;
        rsp_ready_i  = 1'b1;
      end
    end
  end

  task automatic send_req(input vfu_op_e op, input vew_e vew, input int vl, input int vs2,
                          input int vs1, input int vd, input logic use_vs1,
                          input logic [31:0] rs1);
    vfu_req_t r;
    int       t;
    logic     done;
    r         = '{id: next_id, op: op, vew: vew, vl: vfu_vl_t'(vl), vs1: vreg_idx_t'(vs1),
                  vs2: vreg_idx_t'(vs2), vd: vreg_idx_t'(vd), use_vs1: use_vs1, rs1: rs1};
    next_id++;
    req_i       = r;
    req_valid_i = 1'b1;
    t           = 0;
    done        = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      if (req_ready_o) begin
        done = 1'b1;
      end else begin
        t++;
        if (t >= TIMEOUT) begin
          $display("Request port never became ready");
          timeouts++;
          done = 1'b1;
        end
      end
    end
    #1 req_valid_i = 1'b0;
  endtask

  // Wait until every accepted request has its response
  task automatic wait_drain();
    int t;
    t = 0;
    while (pending != 0 && t < TIMEOUT) begin
      @(negedge clk_i);
      t++;
    end
    if (pending != 0) begin
      $display("Instructions did not complete in time");
      timeouts++;
    end
    @(posedge clk_i);
    #1;
  endtask

  initial begin
    int          epw;
    vew_e        ew;
    seed        = 32'h8efb_0fe5;
    bp_seed     = seed ^ 32'h5a5a_5a5a;
    bp_on       = 1'b0;
    timeouts    = 0;
    next_id     = '0;
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    for (int i = 0; i < N_VREGS*WORDS_PER_VREG; i++) begin
      mem[i] = {$random(seed), $random(seed)};
    end
    // Registers 30 and 31 hold values on both sides of the sign boundary
    for (int k = 0; k < WORDS_PER_VREG; k++) begin
      mem[30*WORDS_PER_VREG + k] = 64'h807f_ff01_7fff_8000 ^ (64'(k) << 8);
      mem[31*WORDS_PER_VREG + k] = 64'h7f80_01ff_8000_7fff ^ (64'(k) << 16);
    end
    for (int i = 0; i < N_VREGS*WORDS_PER_VREG; i++) begin
      checker_inst.shadow[i] = mem[i];
    end
    repeat (4) @(posedge clk_i);
    #1 rst_i = 1'b0;

    // Vector-vector at each element width
    for (int v = 0; v < 3; v++) begin
      ew  = vew_e'(v);
      epw = VRF_BE_W >> v;
      for (int op = 0; op < 5; op++) begin
        send_req(vfu_op_e'(op), ew, 4*epw, 1 + op, 10, 20 + v, 1'b1, '0);
      end
    end
    send_req(OP_MIN, EW_8, 32, 30, 31, 24, 1'b1, '0);
    send_req(OP_MAX, EW_8, 32, 30, 31, 25, 1'b1, '0);
    send_req(OP_MIN, EW_16, 16, 31, 30, 26, 1'b1, '0);
    send_req(OP_MAX, EW_16, 16, 31, 30, 27, 1'b1, '0);
    // Vector-scalar forms
    send_req(OP_ADD, EW_8, 32, 30, 0, 12, 1'b0, 32'h0000_0080);
    send_req(OP_MAX, EW_16, 16, 31, 0, 13, 1'b0, 32'h0001_8001);
    send_req(OP_XOR, EW_32, 8, 5, 0, 14, 1'b0, 32'hdead_beef);
    send_req(OP_MIN, EW_8, 32, 31, 0, 15, 1'b0, 32'h0000_007f);
    // Tail masking
    send_req(OP_ADD, EW_8, 5, 2, 3, 16, 1'b1, '0);
    send_req(OP_SUB, EW_16, 7, 2, 3, 17, 1'b1, '0);
    send_req(OP_OR, EW_32, 3, 2, 3, 18, 1'b1, '0);
    send_req(OP_XOR, EW_8, 13, 2, 0, 19, 1'b0, 32'h0000_00a5);
    wait_drain();

    // Random instructions under random stalls
    bp_on = 1'b1;
    for (int n = 0; n < 20; n++) begin
      ew  = vew_e'((32'($random(seed)) & 32'h7fff_ffff) % 3);
      epw = VRF_BE_W >> int'(ew);
      send_req(vfu_op_e'((32'($random(seed)) & 32'h7fff_ffff) % 7), ew,
               1 + (32'($random(seed)) & 32'h7fff_ffff) % (4*epw),
               $random(seed) & 31, $random(seed) & 31, $random(seed) & 31,
               1'($random(seed)), $random(seed));
    end
    wait_drain();

    // Three requests back to back
    send_req(OP_ADD, EW_32, 8, 1, 2, 3, 1'b1, '0);
    send_req(OP_SUB, EW_16, 11, 4, 5, 6, 1'b1, '0);
    send_req(OP_MAX, EW_8, 27, 7, 0, 8, 1'b0, 32'h0000_00c3);
    wait_drain();

    repeat (5) @(posedge clk_i);
    #1;
    $display("Errors: %0d, assertion failures: %0d, timeouts: %0d, responses: %0d",
             errors, vfu_top_inst.assertions_inst.fail_count, timeouts, rsp_count);
    if (errors == 0 && vfu_top_inst.assertions_inst.fail_count == 0 && timeouts == 0 &&
        rsp_count > 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : vfu_tb

/* sim/vfu_checker.sv */
// Result checker for the vector functional unit
// Queues accepted requests, keeps a shadow of the VRF, and compares
// every accepted write and every response with the expected values

`timescale 1ns/1ps

module vfu_checker import vfu_cfg_pkg::*; import vfu_isa_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  vfu_req_t   req_i,
  input  logic       req_valid_i,
  input  logic       req_ready_i,
  input  vfu_rsp_t   rsp_i,
  input  logic       rsp_valid_i,
  input  logic       rsp_ready_i,
  input  logic [1:0] re_i,
  input  logic       we_i,
  input  vrf_addr_t  waddr_i,
  input  vrf_word_t  wdata_i,
  input  vrf_be_t    wbe_i,
  input  logic       wvalid_i,
  output int         errors_o,
  output int         pending_o,
  output int         rsp_count_o
);

  vrf_word_t shadow [N_VREGS*WORDS_PER_VREG];
  vfu_req_t  pend_q [$];
  int        widx;

  // One element of width w, both operands already cut to w bits
  function automatic logic [31:0] elem_ref(vfu_op_e op, logic [31:0] a, logic [31:0] b,
                                           int w);
    int          sa;
    int          sb;
    logic [63:0] r;
    sa = a << (32 - w);
    sa = sa >>> (32 - w);
    sb = b << (32 - w);
    sb = sb >>> (32 - w);
    case (op)
      OP_ADD:  r = b + a;
      OP_SUB:  r = b - a;
      OP_AND:  r = b & a;
      OP_OR:   r = b | a;
      OP_XOR:  r = b ^ a;
      OP_MIN:  r = (sb < sa) ? b : a;
      OP_MAX:  r = (sb > sa) ? b : a;
      default: r = '0;
    endcase
    return 32'(r & ((64'd1 << w) - 1));
  endfunction

  function automatic vrf_word_t ref_word(vrf_word_t a, vrf_word_t b, vfu_op_e op, vew_e vew);
    int          w;
    logic [63:0] m;
    vrf_word_t   res;
    w   = 8 << int'(vew);
    m   = (64'd1 << w) - 1;
    res = '0;
    for (int e = 0; e < VRF_WORD_W / w; e++) begin
      res |= 64'(elem_ref(op, 32'((a >> (e*w)) & m), 32'((b >> (e*w)) & m), w)) << (e*w);
    end
    return res;
  endfunction

  function automatic vrf_word_t scalar_rep(logic [31:0] rs1, vew_e vew);
    int        w;
    vrf_word_t res;
    w   = 8 << int'(vew);
    res = '0;
    for (int e = 0; e < VRF_WORD_W / w; e++) begin
      res |= (64'(rs1) & ((64'd1 << w) - 1)) << (e*w);
    end
    return res;
  endfunction

  function automatic vrf_be_t tail_be(int vl, vew_e vew, int k);
    vrf_be_t be;
    for (int j = 0; j < VRF_BE_W; j++) begin
      be[j] = (k * (VRF_BE_W >> int'(vew)) + (j >> int'(vew))) < vl;
    end
    return be;
  endfunction

  ////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    vfu_req_t  r;
    vrf_word_t a;
    vrf_word_t b;
    vrf_word_t exp_d;
    vrf_be_t   exp_be;
    vrf_addr_t exp_a;
    int        epw;
    if (rst_i) begin
      pend_q.delete();
      widx = 0;
    end else begin
      // Port 0 reads vs2, port 1 reads vs1 of vector-vector forms only
      if (re_i != 2'b00) begin
        if (pend_q.size() == 0) begin
          $display("VRF read requested while no request was pending");
          errors_o++;
        end else if (re_i !== {pend_q[0].use_vs1, 1'b1}) begin
          $display("[ERROR] vrf_re_o got %h expected %h", re_i,
                   {pend_q[0].use_vs1, 1'b1});
          errors_o++;
        end
      end
      if (we_i && wvalid_i) begin
        if (pend_q.size() == 0) begin
          $display("Write accepted while no request was pending");
          errors_o++;
        end else begin
          r      = pend_q[0];
          exp_a  = vrf_addr_t'(int'(r.vd) * WORDS_PER_VREG + widx);
          b      = shadow[int'(r.vs2) * WORDS_PER_VREG + widx];
          a      = r.use_vs1 ? shadow[int'(r.vs1) * WORDS_PER_VREG + widx]
                             : scalar_rep(r.rs1, r.vew);
          exp_d  = ref_word(a, b, r.op, r.vew);
          exp_be = tail_be(int'(r.vl), r.vew, widx);
          if (waddr_i !== exp_a) begin
            $display("[ERROR] vrf_waddr_o got %h expected %h", waddr_i, exp_a);
            errors_o++;
          end
          if (wbe_i !== exp_be) begin
            $display("[ERROR] vrf_wbe_o got %h expected %h", wbe_i, exp_be);
            errors_o++;
          end
          if (wdata_i !== exp_d) begin
            $display("[ERROR] vrf_wdata_o got %h expected %h", wdata_i, exp_d);
            errors_o++;
          end
          for (int j = 0; j < VRF_BE_W; j++) begin
            if (exp_be[j]) begin
              shadow[exp_a][j*8 +: 8] = exp_d[j*8 +: 8];
            end
          end
          widx++;
        end
      end
      if (rsp_valid_i && rsp_ready_i) begin
        if (pend_q.size() == 0) begin
          $display("Response taken while no request was pending");
          errors_o++;
        end else begin
          r   = pend_q.pop_front();
          epw = VRF_BE_W >> int'(r.vew);
          if (rsp_i.id !== r.id) begin
            $display("[ERROR] rsp_o.id got %h expected %h", rsp_i.id, r.id);
            errors_o++;
          end
          // A zero vl still writes one fully masked word
          if (widx != ((int'(r.vl) == 0) ? 1 : (int'(r.vl) + epw - 1) / epw)) begin
            $display("[ERROR] write count got %h expected %h", widx,
                     (int'(r.vl) + epw - 1) / epw);
            errors_o++;
          end
          widx = 0;
          rsp_count_o++;
        end
      end
      if (req_valid_i && req_ready_i) begin
        pend_q.push_back(req_i);
      end
    end
    pending_o = pend_q.size();
  end

  initial begin
    errors_o    = 0;
    pending_o   = 0;
    rsp_count_o = 0;
  end

endmodule : vfu_checker

/* sim/vfu_assertions.sv */
// Handshake assertions for the vector functional unit
// Bound to the top level, watches the VRF write port, the response port
// and the enables while reset is applied

`timescale 1ns/1ps

module vfu_assertions import vfu_cfg_pkg::*; import vfu_isa_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic      [1:0] vrf_re_o,
  input  logic            vrf_we_o,
  input  vrf_addr_t       vrf_waddr_o,
  input  vrf_word_t       vrf_wdata_o,
  input  vrf_be_t         vrf_wbe_o,
  input  logic            vrf_wvalid_i,
  input  vfu_rsp_t        rsp_o,
  input  logic            rsp_valid_o,
  input  logic            rsp_ready_i
);

  // Number of failed assertions
  int fail_count = 0;

  // A held write keeps address, data and enables until taken
  write_held: assert property (@(posedge clk_i) disable iff (rst_i)
    vrf_we_o && !vrf_wvalid_i |=> vrf_we_o && $stable(vrf_waddr_o) &&
      $stable(vrf_wdata_o) && $stable(vrf_wbe_o))
    else begin
      $error("VRF write changed before it was accepted");
      fail_count++;
    end

  rsp_held: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else begin
      $error("Response changed before it was taken");
      fail_count++;
    end

  // Second reset cycle onwards, the flops are settled
  quiet_in_reset: assert property (@(posedge clk_i)
    rst_i && $past(rst_i) |-> !vrf_we_o && (vrf_re_o == 2'b00) && !rsp_valid_o)
    else begin
      $error("Enable high during reset");
      fail_count++;
    end

endmodule : vfu_assertions

bind vfu_top vfu_assertions assertions_inst (.*);

/* src/vfu_top.sv */
// Integer vector functional unit
// Request queue, controller, word counter, operand selection, SIMD lanes
// and result stage, attached to a VRF with two read ports and one write

`timescale 1ns/1ps

module vfu_top import vfu_cfg_pkg::*; import vfu_isa_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  vfu_req_t        req_i,
  input  logic            req_valid_i,
  output logic            req_ready_o,
  output vfu_rsp_t        rsp_o,
  output logic            rsp_valid_o,
  input  logic            rsp_ready_i,
  output logic      [1:0] vrf_re_o,
  output vrf_addr_t [1:0] vrf_raddr_o,
  input  vrf_word_t [1:0] vrf_rdata_i,
  input  logic      [1:0] vrf_rvalid_i,
  output logic            vrf_we_o,
  output vrf_addr_t       vrf_waddr_o,
  output vrf_word_t       vrf_wdata_o,
  output vrf_be_t         vrf_wbe_o,
  input  logic            vrf_wvalid_i
);

  vfu_req_t  head;
  logic      head_valid, head_ready;
  logic      start, issue, rd_ok, stage_free;
  logic      wr_done, last_written;
  logic      cnt_last;
  vrf_addr_t cnt_waddr;
  vrf_be_t   cnt_be;
  vrf_word_t op_a, op_b, result;
  vfu_tag_t  issue_tag;

  vfu_req_queue req_queue_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .head_o       (head),
    .head_valid_o (head_valid),
    .head_ready_i (head_ready)
  );

  // All requested read ports answered
  assign rd_ok = &(vrf_rvalid_i | ~vrf_re_o);

  vfu_controller controller_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .head_i         (head),
    .head_valid_i   (head_valid),
    .head_ready_o   (head_ready),
    .rd_ok_i        (rd_ok),
    .stage_free_i   (stage_free),
    .last_i         (cnt_last),
    .wr_done_i      (wr_done),
    .last_written_i (last_written),
    .start_o        (start),
    .issue_o        (issue),
    .re_o           (vrf_re_o),
    .rsp_o          (rsp_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i)
  );

  vfu_elem_counter elem_counter_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .head_i  (head),
    .start_i (start),
    .issue_i (issue),
    .raddr_o (vrf_raddr_o),
    .waddr_o (cnt_waddr),
    .last_o  (cnt_last),
    .be_o    (cnt_be)
  );

  vfu_operand_sel operand_sel_inst (
    .head_i      (head),
    .vrf_rdata_i (vrf_rdata_i),
    .op_a_o      (op_a),
    .op_b_o      (op_b)
  );

  ////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////

  for (genvar l = 0; l < N_LANES; l++) begin : gen_lanes
    vfu_lane lane_inst (
      .op_i  (head.op),
      .vew_i (head.vew),
      .a_i   (op_a[l*ELEN +: ELEN]),
      .b_i   (op_b[l*ELEN +: ELEN]),
      .res_o (result[l*ELEN +: ELEN])
    );
  end : gen_lanes

  assign issue_tag = '{id: head.id, vew: head.vew, waddr: cnt_waddr, be: cnt_be,
                       last: cnt_last};

  vfu_result_stage result_stage_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .load_i         (issue),
    .data_i         (result),
    .tag_i          (issue_tag),
    .free_o         (stage_free),
    .vrf_we_o       (vrf_we_o),
    .vrf_waddr_o    (vrf_waddr_o),
    .vrf_wdata_o    (vrf_wdata_o),
    .vrf_wbe_o      (vrf_wbe_o),
    .vrf_wvalid_i   (vrf_wvalid_i),
    .wr_done_o      (wr_done),
    .last_written_o (last_written)
  );

endmodule : vfu_top

/* src/vfu_result_stage.sv */
// Result stage of the vector functional unit
// Holds one result word with its tag and presents it on the VRF write
// port until the VRF accepts it. Reloads in the same cycle as the write.

`timescale 1ns/1ps

module vfu_result_stage import vfu_isa_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      load_i,
  input  vrf_word_t data_i,
  input  vfu_tag_t  tag_i,
  output logic      free_o,
  output logic      vrf_we_o,
  output vrf_addr_t vrf_waddr_o,
  output vrf_word_t vrf_wdata_o,
  output vrf_be_t   vrf_wbe_o,
  input  logic      vrf_wvalid_i,
  output logic      wr_done_o,
  output logic      last_written_o
);

  logic      full_q;
  vrf_word_t data_q;
  vfu_tag_t  tag_q;

  assign wr_done_o      = full_q && vrf_wvalid_i;
  assign last_written_o = wr_done_o && tag_q.last;

  // Empty, or the held word leaves this cycle
  assign free_o = !full_q || vrf_wvalid_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (load_i) begin
      full_q <= 1'b1;
    end else if (wr_done_o) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      data_q <= data_i;
      tag_q  <= tag_i;
    end
  end

  ////////////////////////////////////////
  // VRF write port
  ////////////////////////////////////////

  assign vrf_we_o    = full_q;
  assign vrf_waddr_o = tag_q.waddr;
  assign vrf_wdata_o = data_q;
  assign vrf_wbe_o   = tag_q.be;

endmodule : vfu_result_stage

/* src/vfu_lane.sv */
// SIMD integer lane of the vector functional unit
// One 32-bit lane split into four bytes, two halves or one word.
// Each element is worked on alone, so no carry crosses a boundary.

`timescale 1ns/1ps

module vfu_lane import vfu_cfg_pkg::*; import vfu_isa_pkg::*; (
  input  vfu_op_e    op_i,
  input  vew_e       vew_i,
  input  lane_word_u a_i,
  input  lane_word_u b_i,
  output lane_word_u res_o
);

  // Operands come in sign-extended, so the signed compare holds for
  // every element width and the low bits of add and sub stay exact
  function automatic logic [ELEN-1:0] elem_op(vfu_op_e op, logic signed [ELEN-1:0] a,
                                              logic signed [ELEN-1:0] b);
    logic [ELEN-1:0] r;
    unique case (op)
      OP_ADD:  r = b + a;
      OP_SUB:  r = b - a;
      OP_AND:  r = b & a;
      OP_OR:   r = b | a;
      OP_XOR:  r = b ^ a;
      OP_MIN:  r = (b < a) ? b : a;
      OP_MAX:  r = (b > a) ? b : a;
      default: r = '0;
    endcase
    return r;
  endfunction

  always_comb begin
    logic [ELEN-1:0] tmp;
    res_o = '0;
    unique case (vew_i)
      EW_8: begin
        for (int i = 0; i < ELENB; i++) begin
          tmp          = elem_op(op_i, ELEN'($signed(a_i.b[i])), ELEN'($signed(b_i.b[i])));
          res_o.b[i]   = tmp[7:0];
        end
      end
      EW_16: begin
        for (int i = 0; i < ELENB/2; i++) begin
          tmp          = elem_op(op_i, ELEN'($signed(a_i.h[i])), ELEN'($signed(b_i.h[i])));
          res_o.h[i]   = tmp[15:0];
        end
      end
      default: begin
        res_o.w = elem_op(op_i, a_i.w, b_i.w);
      end
    endcase
  end

endmodule : vfu_lane

/* src/vfu_operand_sel.sv */
// Operand selection of the vector functional unit
// Operand b is always vs2. Operand a is vs1 or rs1 replicated across the
// word according to the element width.

`timescale 1ns/1ps

module vfu_operand_sel import vfu_cfg_pkg::*; import vfu_isa_pkg::*; (
  input  vfu_req_t        head_i,
  input  vrf_word_t [1:0] vrf_rdata_i,
  output vrf_word_t       op_a_o,
  output vrf_word_t       op_b_o
);

  vrf_word_t rs1_rep;

  always_comb begin
    unique case (head_i.vew)
      EW_8:    rs1_rep = {VRF_BE_W{head_i.rs1[7:0]}};
      EW_16:   rs1_rep = {(VRF_BE_W/2){head_i.rs1[15:0]}};
      default: rs1_rep = {N_LANES{head_i.rs1}};
    endcase
  end

  assign op_a_o = head_i.use_vs1 ? vrf_rdata_i[1] : rs1_rep;
  assign op_b_o = vrf_rdata_i[0];

endmodule : vfu_operand_sel

/* src/vfu_elem_counter.sv */
// Word counter of the vector functional unit
// Tracks the word index of the running instruction and derives the VRF
// addresses, the last-word flag and the tail byte enables from vl and vew

`timescale 1ns/1ps

module vfu_elem_counter import vfu_cfg_pkg::*; import vfu_isa_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  vfu_req_t        head_i,
  input  logic            start_i,
  input  logic            issue_i,
  output vrf_addr_t [1:0] raddr_o,
  output vrf_addr_t       waddr_o,
  output logic            last_o,
  output vrf_be_t         be_o
);

  logic [WIDX_W-1:0] widx_q;
  logic [2:0]        epw_log2;
  logic [VL_W:0]     epw;
  logic [VL_W:0]     elem_base;
  logic [VL_W:0]     vl_ext;

  always_ff @(posedge clk_i) begin
    if (rst_i || start_i) begin
      widx_q <= '0;
    end else if (issue_i) begin
      widx_q <= widx_q + 1'b1;
    end
  end

  // Elements per word: 8, 4 or 2
  assign epw_log2  = 3'($clog2(VRF_BE_W)) - 3'(head_i.vew);
  assign epw       = (VL_W+1)'(1) << epw_log2;
  assign elem_base = (VL_W+1)'(widx_q) << epw_log2;
  assign vl_ext    = (VL_W+1)'(head_i.vl);

  // Last word once it covers element vl-1, or at once for vl of zero
  assign last_o = (elem_base + epw) >= vl_ext;

  // Tail mask, one element spans 1, 2 or 4 bytes
  always_comb begin
    for (int b = 0; b < VRF_BE_W; b++) begin
      be_o[b] = (elem_base + ((VL_W+1)'(b) >> head_i.vew)) < vl_ext;
    end
  end

  ////////////////////////////////////////
  // Addresses
  ////////////////////////////////////////

  // Register number times WORDS_PER_VREG plus the word index
  assign raddr_o[0] = {head_i.vs2, widx_q};
  assign raddr_o[1] = {head_i.vs1, widx_q};
  assign waddr_o    = {head_i.vd, widx_q};

endmodule : vfu_elem_counter

/* src/vfu_controller.sv */
// Vector functional unit controller
// Runs one instruction at a time: start, issue of all words, drain of
// the result stage, then the response. The head leaves the queue once
// the response has been taken.

`timescale 1ns/1ps

module vfu_controller import vfu_isa_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  vfu_req_t   head_i,
  input  logic       head_valid_i,
  output logic       head_ready_o,
  input  logic       rd_ok_i,
  input  logic       stage_free_i,
  input  logic       last_i,
  input  logic       wr_done_i,
  input  logic       last_written_i,
  output logic       start_o,
  output logic       issue_o,
  output logic [1:0] re_o,
  output vfu_rsp_t   rsp_o,
  output logic       rsp_valid_o,
  input  logic       rsp_ready_i
);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN,
    RESPOND
  } state_e;

  state_e state_q, state_d;

  always_comb begin
    state_d      = state_q;
    start_o      = 1'b0;
    issue_o      = 1'b0;
    re_o         = 2'b00;
    head_ready_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (head_valid_i) begin
          start_o = 1'b1;
          state_d = ISSUE;
        end
      end
      ISSUE: begin
        // Port 0 is vs2, port 1 only for vector-vector forms
        re_o    = {head_i.use_vs1, 1'b1};
        issue_o = rd_ok_i && stage_free_i;
        if (issue_o && last_i) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        if (wr_done_i && last_written_i) begin
          state_d = RESPOND;
        end
      end
      RESPOND: begin
        if (rsp_ready_i) begin
          head_ready_o = 1'b1;
          state_d      = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign rsp_valid_o = (state_q == RESPOND);
  assign rsp_o       = '{id: head_i.id};

endmodule : vfu_controller

/* src/vfu_req_queue.sv */
// Request queue of the vector functional unit
// Two-slot spill register between the request port and the controller.
// Ready comes from flops only, so the port never waits on the FSM.

`timescale 1ns/1ps

module vfu_req_queue import vfu_isa_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  vfu_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output vfu_req_t head_o,
  output logic     head_valid_o,
  input  logic     head_ready_i
);

  // Slot a takes new requests, slot b holds the older one when stalled
  vfu_req_t a_data_q, b_data_q;
  logic     a_full_q, b_full_q;
  logic     a_fill, a_drain, b_fill, b_drain;

  assign a_fill  = req_valid_i && req_ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !head_ready_i;
  assign b_drain = b_full_q && head_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill) begin
        a_full_q <= 1'b1;
      end else if (a_drain) begin
        a_full_q <= 1'b0;
      end
      if (b_fill) begin
        b_full_q <= 1'b1;
      end else if (b_drain) begin
        b_full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= req_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  assign req_ready_o  = !a_full_q || !b_full_q;
  assign head_valid_o = a_full_q || b_full_q;
  assign head_o       = b_full_q ? b_data_q : a_data_q;

endmodule : vfu_req_queue

/* src/vfu_isa_pkg.sv */
// Vector functional unit instruction types
// Operations, element widths, request and response formats, the tag
// that follows a result word, and the lane word views

package vfu_isa_pkg;

  import vfu_cfg_pkg::*;

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_MIN = 3'd5,
    OP_MAX = 3'd6
  } vfu_op_e;

  // Encoded as log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vew_e;

  typedef logic [VRF_WORD_W-1:0] vrf_word_t;
  typedef logic [VRF_ADDR_W-1:0] vrf_addr_t;
  typedef logic [VRF_BE_W-1:0]   vrf_be_t;
  typedef logic [VREG_IDX_W-1:0] vreg_idx_t;
  typedef logic [ID_W-1:0]       vfu_id_t;
  typedef logic [VL_W-1:0]       vfu_vl_t;

  typedef struct packed {
    vfu_id_t         id;
    vfu_op_e         op;
    vew_e            vew;
    vfu_vl_t         vl;
    vreg_idx_t       vs1;
    vreg_idx_t       vs2;
    vreg_idx_t       vd;
    logic            use_vs1;
    logic [ELEN-1:0] rs1;
  } vfu_req_t;

  typedef struct packed {
    vfu_id_t id;
  } vfu_rsp_t;

  typedef struct packed {
    vfu_id_t   id;
    vew_e      vew;
    vrf_addr_t waddr;
    vrf_be_t   be;
    logic      last;
  } vfu_tag_t;

  // One lane word, read per element width
  typedef union packed {
    logic [ELENB-1:0][7:0]     b;
    logic [ELENB/2-1:0][15:0]  h;
    logic [ELEN-1:0]           w;
  } lane_word_u;

endpackage : vfu_isa_pkg

/* src/vfu_cfg_pkg.sv */
// Vector functional unit configuration
// Lane count, VRF geometry and the widths of ids and vector lengths

package vfu_cfg_pkg;

  ////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////

  localparam int N_LANES = 2;
  localparam int ELEN    = 32;
  localparam int ELENB   = ELEN / 8;

  // One VRF word spans all lanes
  localparam int VRF_WORD_W = N_LANES * ELEN;
  localparam int VRF_BE_W   = N_LANES * ELENB;

  ////////////////////////////////////////
  // Register file geometry
  ////////////////////////////////////////

  localparam int N_VREGS        = 32;
  localparam int WORDS_PER_VREG = 4;
  localparam int VREG_IDX_W     = $clog2(N_VREGS);
  localparam int WIDX_W         = $clog2(WORDS_PER_VREG);
  localparam int VRF_ADDR_W     = VREG_IDX_W + WIDX_W;

  // Instruction bookkeeping
  localparam int ID_W = 3;
  // Must hold a vl of 32 byte elements
  localparam int VL_W = $clog2(WORDS_PER_VREG * VRF_BE_W) + 1;

endpackage : vfu_cfg_pkg
